// File: qe_pkg.sv
/*
 * Quadrature encoder channel definitions.
 * Register map, configuration and status layouts, the quadrature
 * signal set and the encoder direction values shared by the channel.
 */
`default_nettype none

package qe_pkg;

    //////////////////////////////////////////////////////////////////////
    // register word
    //////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;

    typedef logic [data_width-1:0] qe_word_t;

    // local register addresses of one channel
    typedef enum logic [2:0] {
        qe_reg_count          = 3'd0,
        qe_reg_turns          = 3'd1,
        qe_reg_phase_time     = 3'd2,
        qe_reg_counts_per_rev = 3'd3,
        qe_reg_config         = 3'd4,
        qe_reg_status         = 3'd5
    } qe_reg_addr_e;

    //////////////////////////////////////////////////////////////////////
    // encoder signals and direction
    //////////////////////////////////////////////////////////////////////

    localparam logic qe_cw  = 1'b0;
    localparam logic qe_ccw = 1'b1;

    // config register bits, source sits in bit 0
    typedef struct packed {
        logic flip_ab;
        logic sim_direction;
        logic sim_enable;
        // 0 = external pins, 1 = internal simulator
        logic source;
    } qe_config_t;

    // i on top so the status halves read i, b, a
    typedef struct packed {
        logic i;
        logic b;
        logic a;
    } qe_quad_t;

    typedef struct packed {
        qe_quad_t sel;
        qe_quad_t ext;
    } qe_status_t;

endpackage

`default_nettype wire

// File: qe_regs.sv
/*
 * Quadrature encoder register block.
 * Holds phase time, counts per revolution and the config word, builds
 * the status word and returns registered read data on a read strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_regs
    import qe_pkg::*;
#(
    parameter int addr_width = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  logic [addr_width-1:0] reg_addr,
    input  qe_word_t              reg_wdata,
    input  qe_word_t              count,
    input  qe_word_t              turns,
    input  qe_quad_t              sel_quad,
    input  qe_quad_t              ext_sync,
    output qe_word_t              reg_rdata,
    output qe_config_t            cfg,
    output qe_word_t              phase_time,
    output qe_word_t              counts_per_rev
);

    qe_status_t status;
    qe_word_t   rd_mux;

    // live pin levels, selected set in the upper half
    assign status.sel = sel_quad;
    assign status.ext = ext_sync;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////

    // read-only and unused addresses drop the write
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_time     <= '0;
            counts_per_rev <= '0;
            cfg            <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                addr_width'(qe_reg_phase_time):     phase_time <= reg_wdata;
                addr_width'(qe_reg_counts_per_rev): counts_per_rev <= reg_wdata;
                // upper config bits are not stored
                addr_width'(qe_reg_config):         cfg <= reg_wdata[$bits(qe_config_t)-1:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_addr)
            addr_width'(qe_reg_count):          rd_mux = count;
            addr_width'(qe_reg_turns):          rd_mux = turns;
            addr_width'(qe_reg_phase_time):     rd_mux = phase_time;
            addr_width'(qe_reg_counts_per_rev): rd_mux = counts_per_rev;
            addr_width'(qe_reg_config):
                rd_mux = {{(data_width - $bits(qe_config_t)){1'b0}}, cfg};
            addr_width'(qe_reg_status):
                rd_mux = {{(data_width - $bits(qe_status_t)){1'b0}}, status};
            default:                            rd_mux = '0;
        endcase
    end

    // read data loads on the strobe and holds until the next read
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: qe_sim_gen.sv
/*
 * Simulated quadrature encoder.
 * A phase timer paces four-step quadrature sequences in either
 * direction, and a step counter raises the index once per revolution.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_sim_gen
    import qe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  logic     direction,
    input  qe_word_t phase_time,
    input  qe_word_t counts_per_rev,
    output qe_quad_t sim_quad
);

    qe_word_t   timer;
    logic       step;
    logic [1:0] phase;
    qe_word_t   rev_cnt;
    logic       index_q;

    // a step ends on the cycle the timer reads zero
    assign step = enable && (timer == '0);

    //////////////////////////////////////////////////////////////////////
    // phase timer and sequencer
    //////////////////////////////////////////////////////////////////////

    // counts phase_time down to zero, so a step lasts phase_time + 1 cycles
    // held loaded while disabled so the first step is full length
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            timer <= '0;
        end else if (!enable || step) begin
            timer <= phase_time;
        end else begin
            timer <= timer - 1'b1;
        end
    end

    // phase holds while disabled
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase <= 2'd0;
        end else if (step) begin
            phase <= phase + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pulse per revolution
    //////////////////////////////////////////////////////////////////////

    // rev_cnt is the entered step number modulo counts_per_rev
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rev_cnt <= '0;
            index_q <= 1'b0;
        end else if (!enable) begin
            index_q <= 1'b0;
        end else if (step) begin
            if (counts_per_rev == '0) begin
                // zero means no index at all
                rev_cnt <= '0;
                index_q <= 1'b0;
            end else if (rev_cnt >= counts_per_rev - 1'b1) begin
                rev_cnt <= '0;
                index_q <= 1'b1;
            end else begin
                rev_cnt <= rev_cnt + 1'b1;
                index_q <= 1'b0;
            end
        end
    end

    // cw: 00 10 11 01, ccw: 00 01 11 10
    always_comb begin
        sim_quad.i = enable & index_q;
        case (phase)
            2'd0:    {sim_quad.a, sim_quad.b} = 2'b00;
            2'd1:    {sim_quad.a, sim_quad.b} = (direction == qe_cw) ? 2'b10 : 2'b01;
            2'd2:    {sim_quad.a, sim_quad.b} = 2'b11;
            default: {sim_quad.a, sim_quad.b} = (direction == qe_cw) ? 2'b01 : 2'b10;
        endcase
    end

endmodule

`default_nettype wire

// File: qe_input_select.sv
/*
 * Quadrature input selection.
 * Resynchronises the external encoder pins, picks the external or
 * simulated source and optionally swaps the a and b channels.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_input_select
    import qe_pkg::*;
#(
    parameter int sync_stages = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  qe_quad_t ext_quad,
    input  qe_quad_t sim_quad,
    input  logic     source,
    input  logic     flip_ab,
    output qe_quad_t sel_quad,
    output qe_quad_t ext_sync
);

    qe_quad_t sync_chain [sync_stages];
    qe_quad_t src_quad;

    // flip-flop chain per pin, stage 0 samples the asynchronous input
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < sync_stages; s++) begin
                sync_chain[s] <= '0;
            end
        end else begin
            sync_chain[0] <= ext_quad;
            for (int s = 1; s < sync_stages; s++) begin
                sync_chain[s] <= sync_chain[s-1];
            end
        end
    end

    assign ext_sync = sync_chain[sync_stages-1];

    // source 1 takes the simulator, no extra delay on that path
    assign src_quad = source ? sim_quad : ext_sync;

    // swap reverses the decoded direction, index passes straight
    assign sel_quad.i = src_quad.i;
    assign sel_quad.a = flip_ab ? src_quad.b : src_quad.a;
    assign sel_quad.b = flip_ab ? src_quad.a : src_quad.b;

endmodule

`default_nettype wire

// File: qe_decoder.sv
/*
 * Quadrature decoder.
 * Compares the current a/b pair against the previous one and issues a
 * one-cycle count pulse with direction, plus an index pulse on i rising.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_decoder
    import qe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  qe_quad_t quad,
    output logic     count_pulse,
    output logic     direction,
    output logic     index_pulse
);

    logic [1:0] prev_ab;
    logic       prev_i;
    logic [1:0] cur_ab;
    logic       one_step;
    logic       cw_step;

    assign cur_ab = {quad.a, quad.b};

    // exactly one of a and b changed, a double change is a glitch
    assign one_step = ^(cur_ab ^ prev_ab);

    // along 00 10 11 01 the new b always equals the old a
    assign cw_step = (cur_ab[0] == prev_ab[1]);

    //////////////////////////////////////////////////////////////////////
    // edge detection
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prev_ab     <= 2'b00;
            prev_i      <= 1'b0;
            count_pulse <= 1'b0;
            index_pulse <= 1'b0;
            direction   <= qe_cw;
        end else begin
            // previous pair follows every sample, ignored steps included
            prev_ab     <= cur_ab;
            prev_i      <= quad.i;
            count_pulse <= one_step;
            index_pulse <= quad.i & ~prev_i;
            // direction is a level, kept until the next legal step
            if (one_step) begin
                direction <= cw_step ? qe_cw : qe_ccw;
            end
        end
    end

endmodule

`default_nettype wire

// File: qe_counters.sv
/*
 * Position and turns counters.
 * Signed 32-bit counts, one step per count pulse and per index pulse,
 * signed by the decoded direction.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_counters
    import qe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     count_pulse,
    input  logic     index_pulse,
    input  logic     direction,
    output qe_word_t count,
    output qe_word_t turns
);

    qe_word_t delta;

    // plus one clockwise, all ones (minus one) counter-clockwise
    assign delta = (direction == qe_cw) ? qe_word_t'(1) : '1;

    // both counters may move in the same cycle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count <= '0;
            turns <= '0;
        end else begin
            if (count_pulse) begin
                count <= count + delta;
            end
            if (index_pulse) begin
                turns <= turns + delta;
            end
        end
    end

endmodule

`default_nettype wire

// File: qe_channel.sv
/*
 * Quadrature encoder channel.
 * Register block, encoder simulator, input selection, decoder and
 * position/turns counters behind a plain strobe register port.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_channel
    import qe_pkg::*;
#(
    parameter int sync_stages = 2,
    parameter int addr_width  = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  logic [addr_width-1:0] reg_addr,
    input  qe_word_t              reg_wdata,
    output qe_word_t              reg_rdata,
    // asynchronous encoder pins
    input  qe_quad_t              ext_quad
);

    qe_config_t cfg;
    qe_word_t   phase_time;
    qe_word_t   counts_per_rev;
    qe_quad_t   sim_quad;
    qe_quad_t   sel_quad;
    qe_quad_t   ext_sync;
    logic       count_pulse;
    logic       direction;
    logic       index_pulse;
    qe_word_t   count;
    qe_word_t   turns;

    //////////////////////////////////////////////////////////////////////
    // register block
    //////////////////////////////////////////////////////////////////////

    qe_regs #(
        .addr_width(addr_width)
    ) regs0 (
        .clk            (clk),
        .reset          (reset),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .count          (count),
        .turns          (turns),
        .sel_quad       (sel_quad),
        .ext_sync       (ext_sync),
        .reg_rdata      (reg_rdata),
        .cfg            (cfg),
        .phase_time     (phase_time),
        .counts_per_rev (counts_per_rev)
    );

    //////////////////////////////////////////////////////////////////////
    // signal path: source, decode, count
    //////////////////////////////////////////////////////////////////////

    qe_sim_gen sim_gen0 (
        .clk            (clk),
        .reset          (reset),
        .enable         (cfg.sim_enable),
        .direction      (cfg.sim_direction),
        .phase_time     (phase_time),
        .counts_per_rev (counts_per_rev),
        .sim_quad       (sim_quad)
    );

    // pins take sync_stages cycles, the simulator none
    qe_input_select #(
        .sync_stages(sync_stages)
    ) input_sel0 (
        .clk      (clk),
        .reset    (reset),
        .ext_quad (ext_quad),
        .sim_quad (sim_quad),
        .source   (cfg.source),
        .flip_ab  (cfg.flip_ab),
        .sel_quad (sel_quad),
        .ext_sync (ext_sync)
    );

    qe_decoder decoder0 (
        .clk         (clk),
        .reset       (reset),
        .quad        (sel_quad),
        .count_pulse (count_pulse),
        .direction   (direction),
        .index_pulse (index_pulse)
    );

    qe_counters counters0 (
        .clk         (clk),
        .reset       (reset),
        .count_pulse (count_pulse),
        .index_pulse (index_pulse),
        .direction   (direction),
        .count       (count),
        .turns       (turns)
    );

endmodule

`default_nettype wire

// File: qe_channel_assert.sv
/*
 * Decoder and counter checks for the encoder channel.
 * Count pulses last one cycle, follow an a/b change and move the
 * position by exactly one.
 */
`timescale 1ns/1ps
`default_nettype none

module qe_channel_assert
    import qe_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input qe_quad_t sel_quad,
    input logic     count_pulse,
    input qe_word_t count
);

    logic [1:0] ab;

    assign ab = {sel_quad.a, sel_quad.b};

    a_pulse_single: assert property (@(posedge clk) disable iff (!reset)
        count_pulse |=> !count_pulse)
        else $error("count pulse lasted two cycles");

    // counter moves on the cycle after the pulse
    a_count_step: assert property (@(posedge clk) disable iff (!reset)
        count_pulse |=> (count == $past(count) + 32'd1) ||
                        (count == $past(count) - 32'd1))
        else $error("count did not move by one after a pulse");

    // pulse is registered from the previous two samples of a/b
    a_pulse_cause: assert property (@(posedge clk) disable iff (!reset)
        count_pulse |-> $past(ab) != $past(ab, 2))
        else $error("count pulse without an a/b change");

endmodule

bind qe_channel qe_channel_assert assert0 (
    .clk         (clk),
    .reset       (reset),
    .sel_quad    (sel_quad),
    .count_pulse (count_pulse),
    .count       (count)
);

`default_nettype wire

// File: tb_qe_channel.sv
/*
 * Testbench for the quadrature encoder channel.
 * Checks the register block, then applies a table of external pin
 * sequences and simulator runs, and checks the count, turns and status.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_qe_channel
    import qe_pkg::*;
();

    localparam int num_tests = 7;
    localparam int max_steps = 8;
    localparam int max_hold  = 8;
    // one slot per table entry plus the register test
    localparam int timeout_cycles = (num_tests + 1) * (max_steps * max_hold + 64);

    // pin levels as {i, b, a}
    localparam logic [2:0] ab_00 = 3'b000;
    localparam logic [2:0] ab_10 = 3'b001;
    localparam logic [2:0] ab_11 = 3'b011;
    localparam logic [2:0] ab_01 = 3'b010;
    localparam logic [2:0] idx   = 3'b100;

    // config low bits {flip_ab, sim_direction, sim_enable, source}
    localparam logic [3:0] cfg_ext      = 4'b0000;
    localparam logic [3:0] cfg_ext_flip = 4'b1000;
    localparam logic [3:0] cfg_int_cw   = 4'b0001;
    localparam logic [3:0] cfg_int_ccw  = 4'b0101;
    localparam logic [3:0] cfg_enable   = 4'b0010;

    typedef struct packed {
        logic [3:0]                    cfg;
        qe_word_t                      phase_time;
        qe_word_t                      counts_per_rev;
        logic                          sim_run;
        int                            n_steps;
        int                            hold;
        logic [0:max_steps-1][2:0]     steps;
        int                            run_cycles;
        // expected changes over one test (sim runs keep only the count sign)
        int                            exp_count;
        int                            exp_turns;
        logic [5:0]                    exp_status;
    } test_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     reg_wr;
    logic     reg_rd;
    logic [2:0] reg_addr;
    qe_word_t reg_wdata;
    qe_word_t reg_rdata;
    qe_quad_t ext_quad;

    test_t tests [num_tests];
    string names [num_tests];
    int    checks = 0;
    int    errors = 0;
    int    cycle_cnt = 0;

    qe_channel #(
        .sync_stages (2),
        .addr_width  (3)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .ext_quad  (ext_quad)
    );

    always #50 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // register port
    //////////////////////////////////////////////////////////////////////

    task automatic write_reg(input logic [2:0] addr, input qe_word_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    // rdata loads on the strobe edge and is sampled half a cycle later
    task automatic read_reg(input logic [2:0] addr, output qe_word_t data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd   <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input qe_word_t got, input qe_word_t exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_delta(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %-18s %s", num, name, (errors == errs_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    function automatic test_t ext_entry(input logic [3:0] cfg, input int n,
                                        input logic [0:max_steps-1][2:0] steps,
                                        input int d_count, input int d_turns,
                                        input logic [5:0] status);
        test_t e;
        e            = '0;
        e.cfg        = cfg;
        e.n_steps    = n;
        e.hold       = max_hold;
        e.steps      = steps;
        e.exp_count  = d_count;
        e.exp_turns  = d_turns;
        e.exp_status = status;
        return e;
    endfunction

    // simulator steps every 4 cycles and raises the index every 4 steps
    function automatic test_t sim_entry(input logic [3:0] cfg, input int sign);
        test_t e;
        e                = '0;
        e.cfg            = cfg;
        e.phase_time     = 32'd3;
        e.counts_per_rev = 32'd4;
        e.sim_run        = 1'b1;
        e.run_cycles     = 64;
        e.exp_count      = sign;
        return e;
    endfunction

    task automatic load_tests();
        // 5 cw steps ending at ab 10 so both status halves read 001
        tests[0] = ext_entry(cfg_ext, 5, {ab_10, ab_11, ab_01, ab_00, ab_10, 9'd0},
                             5, 0, 6'b001_001);
        tests[1] = ext_entry(cfg_ext, 5, {ab_00, ab_01, ab_11, ab_10, ab_00, 9'd0},
                             -5, 0, 6'b000_000);
        // cw pins seen through the swap count down
        tests[2] = ext_entry(cfg_ext_flip, 4, {ab_10, ab_11, ab_01, ab_00, 12'd0},
                             -4, 0, 6'b000_000);
        tests[3] = ext_entry(cfg_ext, 8,
                             {ab_10, ab_11, ab_01, ab_00, idx, ab_00, idx, ab_00},
                             4, 2, 6'b000_000);
        tests[4] = ext_entry(cfg_ext, 8,
                             {ab_01, ab_11, ab_10, ab_00, idx, ab_00, idx, ab_00},
                             -4, -2, 6'b000_000);
        tests[5] = sim_entry(cfg_int_cw, 1);
        tests[6] = sim_entry(cfg_int_ccw, -1);
        names[0] = "ext cw";
        names[1] = "ext ccw";
        names[2] = "ext cw swapped";
        names[3] = "ext index cw";
        names[4] = "ext index ccw";
        names[5] = "sim cw";
        names[6] = "sim ccw";
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_registers();
        qe_word_t   rd;
        int         errs_before;
        logic [2:0] ro_addrs [5] = '{3'd0, 3'd1, 3'd5, 3'd6, 3'd7};
        errs_before = errors;
        for (int a = 0; a < 8; a++) begin
            read_reg(3'(a), rd);
            check_word($sformatf("register %0d after reset", a), rd, '0);
        end
        write_reg(qe_reg_phase_time, 32'hdead_beef);
        write_reg(qe_reg_counts_per_rev, 32'h1234_5678);
        // all config bits set while the long phase time keeps the simulator still
        write_reg(qe_reg_config, 32'hffff_ffff);
        for (int k = 0; k < 5; k++) begin
            write_reg(ro_addrs[k], '1);
        end
        read_reg(qe_reg_phase_time, rd);
        check_word("phase_time", rd, 32'hdead_beef);
        read_reg(qe_reg_counts_per_rev, rd);
        check_word("counts_per_rev", rd, 32'h1234_5678);
        read_reg(qe_reg_config, rd);
        check_word("config", rd, 32'h0000_000f);
        for (int k = 0; k < 5; k++) begin
            read_reg(ro_addrs[k], rd);
            check_word($sformatf("register %0d after write", ro_addrs[k]), rd, '0);
        end
        write_reg(qe_reg_config, '0);
        report_test(0, "registers", errs_before);
    endtask

    task automatic run_test(input int t);
        qe_word_t c0;
        qe_word_t t0;
        qe_word_t c1;
        qe_word_t t1;
        qe_word_t st;
        int       dc;
        int       dt;
        int       exp_dt;
        int       errs_before;
        errs_before = errors;
        write_reg(qe_reg_phase_time, tests[t].phase_time);
        write_reg(qe_reg_counts_per_rev, tests[t].counts_per_rev);
        write_reg(qe_reg_config, {28'd0, tests[t].cfg});
        repeat (8) @(posedge clk);
        read_reg(qe_reg_count, c0);
        read_reg(qe_reg_turns, t0);
        if (tests[t].sim_run) begin
            write_reg(qe_reg_config, {28'd0, tests[t].cfg | cfg_enable});
            repeat (tests[t].run_cycles) @(posedge clk);
            write_reg(qe_reg_config, {28'd0, tests[t].cfg});
        end else begin
            for (int s = 0; s < tests[t].n_steps; s++) begin
                @(posedge clk);
                ext_quad <= tests[t].steps[s];
                repeat (tests[t].hold - 1) @(posedge clk);
            end
        end
        // sync, decode and count pipeline drains
        repeat (16) @(posedge clk);
        read_reg(qe_reg_count, c1);
        read_reg(qe_reg_turns, t1);
        read_reg(qe_reg_status, st);
        dc = int'(c1 - c0);
        dt = int'(t1 - t0);
        if (tests[t].sim_run) begin
            checks++;
            assert (dc != 0 && ((dc > 0) == (tests[t].exp_count > 0))) else begin
                $display("MISMATCH at %0t ns: count change %0d has the wrong sign", $time, dc);
                errors++;
            end
            // one index per full revolution in the direction of travel
            exp_dt = ((dc < 0) ? -dc : dc) / int'(tests[t].counts_per_rev);
            if (dc < 0) begin
                exp_dt = -exp_dt;
            end
            check_delta("turns change", dt, exp_dt);
        end else begin
            check_delta("count change", dc, tests[t].exp_count);
            check_delta("turns change", dt, tests[t].exp_turns);
        end
        check_word("status", st, {26'd0, tests[t].exp_status});
        report_test(t + 1, names[t], errs_before);
    endtask

    initial begin
        reset     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        ext_quad  = '0;
        load_tests();
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        test_registers();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests + 1, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: qe_channel.f
qe_pkg.sv
qe_regs.sv
qe_sim_gen.sv
qe_input_select.sv
qe_decoder.sv
qe_counters.sv
qe_channel.sv
qe_channel_assert.sv
tb_qe_channel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the encoder channel testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f qe_channel.f \
    --top-module tb_qe_channel -o sim_qe_channel

./obj_dir/sim_qe_channel 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
